// File: build.f
hdl/arrayPkg.sv
hdl/arrayIfs.sv
hdl/elementAlu.sv
hdl/elementStore.sv
hdl/arrayAllocator.sv
hdl/arraySizeTable.sv
hdl/arrayController.sv
hdl/arrayMemory.sv
verification/arrayMemoryTb.sv

// File: Makefile
# Verilator build and run of the managed array memory testbench
TOP = arrayMemoryTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: verification/arrayMemoryTb.sv
// Directed testbench for the managed array memory
// Reference model, compare tasks, clock and reset, one task per behavior
`timescale 1ns/1ps

module arrayMemoryTb import arrayPkg::*;;
  localparam int addressBits = defaultAddressBits;
  localparam int indexBits   = defaultIndexBits;
  localparam int dataBits    = defaultDataBits;
  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam int resetLimit  = 20;                        // Cycles allowed for reset release

  logic                   clock;
  logic                   rstN;
  actionT                 action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    in;
  logic [dataBits-1:0]    out;
  errorT                  error;

  // Reference model state
  logic [dataBits-1:0] modelElems [arrays][arrayLength];
  int                  modelSizes [arrays];
  bit                  modelInUse [arrays];
  int                  highWater;
  int                  freedStack [$];
  logic [dataBits-1:0] expOut;
  errorT               expError;

  arrayMemory i_dut (
    .clock (clock),
    .rstN  (rstN),
    .action(action),
    .array (array),
    .index (index),
    .in    (in),
    .out   (out),
    .error (error)
  );

  always #50 clock = ~clock;

  task automatic checkOut(input string name, input logic [dataBits-1:0] actual,
                          input logic [dataBits-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic checkError(input string name, input errorT actual, input errorT expected);
    if (actual !== expected) begin
      $display("ERR %0t %s got %s expected %s", $time, name, actual.name(), expected.name());
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic bit isArith(input actionT act);
    return act inside {actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft,
                       actShiftRight, actNot, actOr, actXor, actAnd};
  endfunction

  function automatic logic [dataBits-1:0] arithResult(input actionT act,
      input logic [dataBits-1:0] value, input logic [dataBits-1:0] operand);
    case (act)
      actAdd, actAddAfter:      return value + operand;
      actSubtract, actSubAfter: return value - operand;
      actShiftLeft:             return value << operand;
      actShiftRight:            return value >> operand;
      actNot:                   return ~value;
      actOr:                    return value | operand;
      actXor:                   return value ^ operand;
      default:                  return value & operand;
    endcase
  endfunction

  // Predicts out and error and updates the state only on success
  task automatic modelStep(input actionT act, input int arr, input int idx,
                           input logic [dataBits-1:0] value);
    int                  num;
    logic [dataBits-1:0] oldValue;
    logic [dataBits-1:0] newValue;
    expError = errNone;
    if (act == actAlloc) begin
      if (freedStack.size() == 0 && highWater == arrays) expError = errOutOfMemory;
    end
    else if (arr >= highWater) expError = errNotAllocated;
    else if (!modelInUse[arr]) expError = errFreed;
    else if ((act == actRead || isArith(act)) && idx >= modelSizes[arr]) begin
      expError = errOutOfBounds;
    end
    else if (act == actPush && modelSizes[arr] == arrayLength) expError = errFull;
    else if (act == actPop && modelSizes[arr] == 0) expError = errEmpty;
    if (expError == errNone) begin
      oldValue = modelElems[arr][idx];
      case (act)
        actAlloc: begin
          if (freedStack.size() > 0) num = freedStack.pop_back();  // Last freed first
          else begin
            num = highWater;
            highWater++;
          end
          modelInUse[num] = 1'b1;
          modelSizes[num] = 0;
          expOut          = dataBits'(num);
        end
        actFree: begin
          modelInUse[arr] = 1'b0;
          freedStack.push_back(arr);
        end
        actWrite: begin
          modelElems[arr][idx] = value;
          if (idx >= modelSizes[arr]) modelSizes[arr] = idx + 1;
          expOut = value;
        end
        actRead: expOut = oldValue;
        actSize: expOut = dataBits'(modelSizes[arr]);
        actPush: begin
          modelElems[arr][modelSizes[arr]] = value;
          modelSizes[arr]++;
        end
        actPop: begin
          modelSizes[arr]--;
          expOut = modelElems[arr][modelSizes[arr]];
        end
        default: begin
          newValue             = arithResult(act, oldValue, value);
          modelElems[arr][idx] = newValue;
          if (act == actAddAfter || act == actSubAfter) expOut = oldValue;
          else expOut = newValue;
        end
      endcase
    end
  endtask

  // Drives one action on the falling edge and checks it one cycle later
  task automatic runAction(input actionT act, input int arr, input int idx,
                           input logic [dataBits-1:0] value);
    @(negedge clock);
    action = act;
    array  = addressBits'(arr);
    index  = indexBits'(idx);
    in     = value;
    modelStep(act, arr, idx, value);
    @(posedge clock);
    @(negedge clock);
    action = actIdle;
    checkError("error", error, expError);
    checkOut("out", out, expOut);
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (rstN !== 1'b1 && cycles < resetLimit) begin
      @(posedge clock);
      cycles++;
    end
    if (rstN !== 1'b1) begin
      $display("reset was never released");
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic allocAfterReset();
    @(negedge clock);
    checkOut("out", out, '0);
    checkError("error", error, errNone);
    for (int i = 0; i < 3; i++) begin
      runAction(actAlloc, 0, 0, '0);
      checkOut("out", out, dataBits'(i));                 // Fresh numbers in order
    end
  endtask

  task automatic writeThenRead();
    logic [dataBits-1:0] first;
    logic [dataBits-1:0] sixth;
    first = dataBits'($urandom);
    sixth = dataBits'($urandom);
    runAction(actWrite, 0, 0, first);
    runAction(actWrite, 0, 5, sixth);
    runAction(actRead, 0, 0, '0);
    checkOut("out", out, first);
    runAction(actRead, 0, 5, '0);
    checkOut("out", out, sixth);
    runAction(actSize, 0, 0, '0);
    checkOut("out", out, dataBits'(6));
    runAction(actRead, 0, 6, '0);
    checkError("error", error, errOutOfBounds);
    checkOut("out", out, dataBits'(6));                   // Still the size result
  endtask

  task automatic fillAndDrain();
    logic [dataBits-1:0] pushed [arrayLength];
    for (int i = 0; i < arrayLength; i++) begin
      pushed[i] = dataBits'($urandom);
      runAction(actPush, 2, 0, pushed[i]);
    end
    runAction(actPush, 2, 0, dataBits'($urandom));
    checkError("error", error, errFull);
    for (int i = arrayLength - 1; i >= 0; i--) begin
      runAction(actPop, 2, 0, '0);
      checkOut("out", out, pushed[i]);
    end
    runAction(actPop, 2, 0, '0);
    checkError("error", error, errEmpty);
  endtask

  task automatic elementArithmetic();
    actionT              ops [10] = '{actAdd, actAddAfter, actSubtract, actSubAfter,
                                      actShiftLeft, actShiftRight, actNot, actOr,
                                      actXor, actAnd};
    logic [dataBits-1:0] value;
    logic [dataBits-1:0] operand;
    foreach (ops[i]) begin
      value   = dataBits'($urandom);
      operand = dataBits'($urandom);
      if (ops[i] == actShiftLeft || ops[i] == actShiftRight) operand = operand % dataBits;
      runAction(actWrite, 0, 0, value);
      runAction(ops[i], 0, 0, operand);
      if (ops[i] == actAddAfter || ops[i] == actSubAfter) checkOut("out", out, value);
      runAction(actRead, 0, 0, '0);                       // Stored result
    end
  endtask

  task automatic freeAndReuse();
    runAction(actFree, 1, 0, '0);
    checkError("error", error, errNone);
    runAction(actRead, 1, 0, '0);
    checkError("error", error, errFreed);
    runAction(actFree, 1, 0, '0);                         // Double free
    checkError("error", error, errFreed);
    runAction(actRead, 9, 0, '0);
    checkError("error", error, errNotAllocated);
    runAction(actAlloc, 0, 0, '0);
    checkOut("out", out, dataBits'(1));
  endtask

  task automatic runOutOfArrays();
    for (int i = 3; i < arrays; i++) begin
      runAction(actAlloc, 0, 0, '0);
      checkOut("out", out, dataBits'(i));
    end
    runAction(actAlloc, 0, 0, '0);
    checkError("error", error, errOutOfMemory);
  endtask

  initial begin
    clock    = 1'b0;
    rstN     = 1'b0;
    action   = actIdle;
    array    = '0;
    index    = '0;
    in       = '0;
    expOut   = '0;
    expError = errNone;
    repeat (5) @(posedge clock);
    @(negedge clock);
    rstN = 1'b1;
  end

  initial begin
    void'($urandom(32'he537));
    highWater = 0;
    foreach (modelSizes[i]) modelSizes[i] = 0;
    foreach (modelInUse[i]) modelInUse[i] = 1'b0;
    foreach (modelElems[i, j]) modelElems[i][j] = '0;
    waitForReset();
    allocAfterReset();
    writeThenRead();
    fillAndDrain();
    elementArithmetic();
    freeAndReuse();
    runOutOfArrays();
    $display("test passed");
    $finish;
  end

endmodule

// File: hdl/arrayMemory.sv
// Managed array memory top level
// Controller, allocator, size table and element store joined by three buses
`timescale 1ns/1ps

module arrayMemory import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   rstN,
  input  actionT                 action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output errorT                  error
);

  allocIf #(.addressBits(addressBits)) allocBus ();
  sizeIf  #(.addressBits(addressBits), .indexBits(indexBits)) sizeBus ();
  storeIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) storeBus ();

  arrayController #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) i_controller (
    .clock (clock),
    .rstN  (rstN),
    .action(action),
    .array (array),
    .index (index),
    .in    (in),
    .out   (out),
    .error (error),
    .alloc (allocBus.ctrl),
    .sizes (sizeBus.ctrl),
    .store (storeBus.ctrl)
  );

  arrayAllocator #(.addressBits(addressBits)) i_allocator (
    .clock(clock), .rstN(rstN), .alloc(allocBus.unit));

  arraySizeTable #(.addressBits(addressBits), .indexBits(indexBits)) i_sizeTable (
    .clock(clock), .rstN(rstN), .sizes(sizeBus.unit));

  elementStore #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    i_store (.clock(clock), .store(storeBus.unit));

endmodule

// File: hdl/arrayController.sv
// Action decoder and access checker
// Drives the allocator, size table and element store, registers out and error
`timescale 1ns/1ps

module arrayController import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   rstN,
  input  actionT                 action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output errorT                  error,
  allocIf.ctrl                   alloc,
  sizeIf.ctrl                    sizes,
  storeIf.ctrl                   store
);
  localparam int arrayLength = 2 ** indexBits;

  logic                 known;                            // Kept action, not idle
  logic                 needBounds;                       // Index must be below size
  logic                 doAlloc;
  logic                 doRelease;
  logic                 doWrite;
  sizeCmdT              sizeCmd;
  elemOpT               elemOp;
  logic [indexBits-1:0] storeIndex;
  logic [dataBits-1:0]  nextOut;
  errorT                checkError;
  logic                 ok;
  logic                 inBounds;
  logic                 full;
  logic                 empty;

  assign inBounds = {1'b0, index} < sizes.size;
  assign full     = sizes.size == (indexBits + 1)'(arrayLength);
  assign empty    = sizes.size == '0;

  always_comb begin
    known      = 1'b1;
    needBounds = 1'b0;
    doAlloc    = 1'b0;
    doRelease  = 1'b0;
    doWrite    = 1'b0;
    sizeCmd    = sizeHold;
    elemOp     = opPass;
    storeIndex = index;
    nextOut    = out;
    case (action)
      actWrite: begin
        doWrite = 1'b1;
        sizeCmd = sizeExtendTo;
        nextOut = in;
      end
      actRead: begin
        needBounds = 1'b1;
        nextOut    = store.oldValue;
      end
      actSize: nextOut = dataBits'(sizes.size);
      actPush: begin
        storeIndex = sizes.size[indexBits-1:0];           // Next free slot
        doWrite    = 1'b1;
        sizeCmd    = sizeIncrement;
      end
      actPop: begin
        storeIndex = sizes.size[indexBits-1:0] - 1'b1;    // Last used slot
        sizeCmd    = sizeDecrement;
        nextOut    = store.oldValue;
      end
      actAlloc: begin
        doAlloc = 1'b1;
        sizeCmd = sizeClear;
        nextOut = dataBits'(alloc.newArray);
      end
      actFree: doRelease = 1'b1;
      actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft, actShiftRight,
      actNot, actOr, actXor, actAnd: begin
        needBounds = 1'b1;
        doWrite    = 1'b1;
        case (action)
          actAdd, actAddAfter:      elemOp = opAdd;
          actSubtract, actSubAfter: elemOp = opSub;
          actShiftLeft:             elemOp = opShl;
          actShiftRight:            elemOp = opShr;
          actNot:                   elemOp = opNot;
          actOr:                    elemOp = opOr;
          actXor:                   elemOp = opXor;
          default:                  elemOp = opAnd;
        endcase
        if (action == actAddAfter || action == actSubAfter) nextOut = store.oldValue;
        else nextOut = store.newValue;
      end
      default: known = 1'b0;                              // Idle or dropped code
    endcase
  end

  // Access checks in priority order starting with the array
  always_comb begin
    checkError = errNone;
    if (action == actAlloc) begin
      if (!alloc.granted) checkError = errOutOfMemory;
    end
    else if (!alloc.everUsed) checkError = errNotAllocated;
    else if (!alloc.inUse) checkError = errFreed;
    else if (needBounds && !inBounds) checkError = errOutOfBounds;
    else if (action == actPush && full) checkError = errFull;
    else if (action == actPop && empty) checkError = errEmpty;
  end

  assign ok = known && (checkError == errNone);

  assign alloc.allocate     = doAlloc && ok;
  assign alloc.releaseArray = doRelease && ok;
  assign alloc.array        = array;

  assign sizes.array       = (action == actAlloc) ? alloc.newArray : array;
  assign sizes.sizeCmd     = ok ? sizeCmd : sizeHold;
  assign sizes.extendIndex = index;

  assign store.write   = doWrite && ok;
  assign store.array   = array;
  assign store.index   = storeIndex;
  assign store.operand = in;
  assign store.elemOp  = elemOp;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      out   <= '0;
      error <= errNone;
    end
    else if (known) begin
      error <= checkError;
      if (checkError == errNone) out <= nextOut;          // Failed check keeps out
    end
  end

endmodule

// File: hdl/arraySizeTable.sv
// Size table
// Current size of every array, with clear, extend, increment and decrement
`timescale 1ns/1ps

module arraySizeTable import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits
) (
  input logic clock,
  input logic rstN,
  sizeIf.unit sizes
);
  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  logic [indexBits:0] sizeMem [arrays];
  logic [indexBits:0] extended;

  assign sizes.size = sizeMem[sizes.array];
  assign extended   = {1'b0, sizes.extendIndex} + 1'b1;   // Size covering the written index

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < arrays; i++) sizeMem[i] <= '0;
    end
    else begin
      case (sizes.sizeCmd)
        sizeClear:     sizeMem[sizes.array] <= '0;
        sizeExtendTo: begin
          if (extended > sizes.size) sizeMem[sizes.array] <= extended;
        end
        sizeIncrement: sizeMem[sizes.array] <= sizes.size + 1'b1;
        sizeDecrement: sizeMem[sizes.array] <= sizes.size - 1'b1;
        default:       ;
      endcase
    end
  end

  // Relies on the controller's full and empty checks
  assert property (@(posedge clock) disable iff (!rstN)
    sizes.size <= (indexBits + 1)'(arrayLength));

endmodule

// File: hdl/arrayAllocator.sv
// Array allocator
// In-use bits, high-water count and a LIFO stack of freed arrays
`timescale 1ns/1ps

module arrayAllocator import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits
) (
  input logic  clock,
  input logic  rstN,
  allocIf.unit alloc
);
  localparam int arrays = 2 ** addressBits;

  logic [arrays-1:0]      inUseBits;
  logic [addressBits:0]   highWater;                      // Arrays ever handed out
  logic [addressBits:0]   stackTop;                       // Entries on freed stack
  logic [addressBits-1:0] freedStack [arrays];
  logic [addressBits-1:0] topIndex;
  logic                   stackValid;

  assign stackValid = stackTop != '0;
  assign topIndex   = stackTop[addressBits-1:0] - 1'b1;   // Wraps correctly when stack is full

  assign alloc.granted  = stackValid || (highWater < (addressBits + 1)'(arrays));
  assign alloc.newArray = stackValid ? freedStack[topIndex] : highWater[addressBits-1:0];
  assign alloc.inUse    = inUseBits[alloc.array];
  assign alloc.everUsed = {1'b0, alloc.array} < highWater;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      inUseBits <= '0;
      highWater <= '0;
      stackTop  <= '0;
    end
    else if (alloc.allocate) begin
      inUseBits[alloc.newArray] <= 1'b1;
      if (stackValid) stackTop <= stackTop - 1'b1;        // Reuse last freed
      else highWater <= highWater + 1'b1;
    end
    else if (alloc.releaseArray) begin
      inUseBits[alloc.array] <= 1'b0;
      stackTop               <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.releaseArray) freedStack[stackTop[addressBits-1:0]] <= alloc.array;
  end

  // Each array sits on the stack at most once
  assert property (@(posedge clock) disable iff (!rstN)
    stackTop <= (addressBits + 1)'(arrays));

endmodule

// File: hdl/elementStore.sv
// Element store
// One memory of fixed-size array blocks with single-cycle read-modify-write
`timescale 1ns/1ps

module elementStore import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input logic  clock,
  storeIf.unit store
);
  localparam int depth = 2 ** (addressBits + indexBits);

  logic [dataBits-1:0]              elements [depth];
  logic [addressBits+indexBits-1:0] address;

  assign address        = {store.array, store.index};     // Array selects the block
  assign store.oldValue = elements[address];

  elementAlu #(
    .dataBits(dataBits)
  ) i_alu (
    .elemOp (store.elemOp),
    .value  (store.oldValue),
    .operand(store.operand),
    .result (store.newValue)
  );

  always_ff @(posedge clock) begin
    if (store.write) elements[address] <= store.newValue;
  end

endmodule

// File: hdl/elementAlu.sv
// Element ALU
// Arithmetic, shift and bitwise operations on one element and an operand
`timescale 1ns/1ps

module elementAlu import arrayPkg::*; #(
  parameter int dataBits = defaultDataBits
) (
  input  elemOpT              elemOp,
  input  logic [dataBits-1:0] value,
  input  logic [dataBits-1:0] operand,
  output logic [dataBits-1:0] result
);

  always_comb begin
    case (elemOp)
      opPass:  result = operand;                          // Plain store for Write and Push
      opAdd:   result = value + operand;
      opSub:   result = value - operand;
      opShl:   result = value << operand;
      opShr:   result = value >> operand;                 // Logical shift
      opNot:   result = ~value;
      opOr:    result = value | operand;
      opXor:   result = value ^ operand;
      opAnd:   result = value & operand;
      default: result = value;
    endcase
  end

endmodule

// File: hdl/arrayIfs.sv
// Buses between the controller and its units
// allocIf carries allocation, sizeIf carries sizes, storeIf carries elements
`timescale 1ns/1ps

interface allocIf import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits
);
  logic                   allocate;                       // Commit grant this edge
  logic                   releaseArray;                   // Free array this edge
  logic [addressBits-1:0] array;                          // Array checked or freed
  logic                   granted;                        // An array is available
  logic [addressBits-1:0] newArray;                       // Number that would be granted
  logic                   inUse;
  logic                   everUsed;

  modport ctrl (
    output allocate, releaseArray, array,
    input  granted, newArray, inUse, everUsed
  );
  modport unit (
    input  allocate, releaseArray, array,
    output granted, newArray, inUse, everUsed
  );
endinterface

interface sizeIf import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits
);
  logic [addressBits-1:0] array;
  sizeCmdT                sizeCmd;
  logic [indexBits-1:0]   extendIndex;                    // Written index for extendTo
  logic [indexBits:0]     size;                           // Current size of array

  modport ctrl (output array, sizeCmd, extendIndex, input size);
  modport unit (input array, sizeCmd, extendIndex, output size);
endinterface

interface storeIf import arrayPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
);
  logic                   write;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    operand;
  elemOpT                 elemOp;
  logic [dataBits-1:0]    oldValue;                       // Element before the action
  logic [dataBits-1:0]    newValue;                       // ALU result

  modport ctrl (output write, array, index, operand, elemOp, input oldValue, newValue);
  modport unit (input write, array, index, operand, elemOp, output oldValue, newValue);
endinterface

// File: hdl/arrayPkg.sv
// Shared definitions for the managed array memory
// Action codes, error codes, element and size operations, default widths
package arrayPkg;

  localparam int defaultAddressBits = 4;                  // 16 arrays
  localparam int defaultIndexBits   = 3;                  // 8 elements per array
  localparam int defaultDataBits    = 16;                 // Element width

  // Caller actions with their fixed command codes
  typedef enum logic [7:0] {
    actIdle       = 8'd0,
    actWrite      = 8'd2,                                 // Write an element
    actRead       = 8'd3,                                 // Read an element
    actSize       = 8'd4,                                 // Current size of array
    actPush       = 8'd14,
    actPop        = 8'd15,
    actAlloc      = 8'd18,                                // New or reused array
    actFree       = 8'd19,
    actAdd        = 8'd20,
    actAddAfter   = 8'd21,                                // Returns previous value
    actSubtract   = 8'd22,
    actSubAfter   = 8'd23,                                // Returns previous value
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNot        = 8'd27,                                // Bitwise
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } actionT;

  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,                                      // Array never handed out
    errFreed,                                             // Array handed out then freed
    errOutOfBounds,                                       // Index at or past size
    errFull,
    errEmpty,
    errOutOfMemory                                        // No array left to allocate
  } errorT;

  typedef enum logic [3:0] {
    opPass, opAdd, opSub, opShl, opShr, opNot, opOr, opXor, opAnd
  } elemOpT;

  typedef enum logic [2:0] {
    sizeHold,
    sizeClear,                                            // Fresh allocation
    sizeExtendTo,                                         // Grow to cover a written index
    sizeIncrement,
    sizeDecrement
  } sizeCmdT;

endpackage
